//--- Bender.yml
package:
  name: cache_tag_ctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - cache_line_regfile.sv
      - cache_replacement_policy.sv
      - cache_tag_lookup.sv
      - cache_req_decoder.sv
      - cache_lookup_resp.sv
      - cache_tag_ctrl_top.sv
      - target: test
        files:
          - tb_cache_tag_ctrl.sv

//--- cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cache geometry
`define CACHE_N_WAYS    8
`define CACHE_NWAYS_W   3        // log2 of the way count
`define CACHE_NLINES_W  4        // 16 lines per way
`define CACHE_OFFSET_W  4        // 16-byte lines
`define CACHE_ADDR_W    24

// whatever is left above index and offset
`define CACHE_TAG_W     (`CACHE_ADDR_W - `CACHE_NLINES_W - `CACHE_OFFSET_W)

// replacement policy codes
`define CACHE_LRU       0        // true lru, one rank per way
`define CACHE_PLRU_MRU  1        // pseudo lru with mru bits
`define CACHE_PLRU_TREE 2        // pseudo lru with a binary tree

// policy picked at build time
`define CACHE_REP_POLICY `CACHE_PLRU_TREE

`endif

//--- cache_line_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cache_line_regfile #(
   parameter int ADDR_W = 4,    // one word per cache line
   parameter int DATA_W = 8
) (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              we,
   input  wire logic [ADDR_W-1:0] addr,
   input  wire logic [DATA_W-1:0] w_data,
   output logic      [DATA_W-1:0] r_data
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] <= '0;   // all lines start empty
         end
      end else if (we) begin
         mem[addr] <= w_data;
      end
   end

   // read is combinational, write lands on the next edge
   assign r_data = mem[addr];

endmodule

`default_nettype wire

//--- cache_lookup_resp.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_lookup_resp import cache_pkg::*; (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire logic                        lk_valid,
   input  wire cache_req_s                  lk_req,
   input  wire logic                        hit,
   input  wire logic [`CACHE_NWAYS_W-1:0]   hit_way,
   input  wire logic [`CACHE_NWAYS_W-1:0]   victim_way,
   input  wire logic                        victim_valid,
   input  wire logic [`CACHE_TAG_W-1:0]     victim_tag,
   output logic                             resp_valid,   // one strobe per request
   output cache_resp_s                      resp
);

   cache_resp_s resp_d;
   logic        alloc_miss;

   assign alloc_miss = (lk_req.op == CACHE_OP_ALLOC) && !hit;

   always_comb begin
      resp_d        = '0;   // evict fields stay clear unless set below
      resp_d.hit    = hit;
      resp_d.victim = victim_way;
      resp_d.op     = lk_req.op;
      resp_d.index  = lk_req.addr.fields.index;

      // a fill uses the victim way, otherwise the hit way
      if (alloc_miss) begin
         resp_d.way = victim_way;
      end else begin
         resp_d.way = hit ? hit_way : '0;
      end

      if (alloc_miss && victim_valid) begin
         resp_d.evict     = 1'b1;   // a live line got replaced
         resp_d.evict_tag = victim_tag;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= lk_valid;
      end
   end

   // payload only moves with a request
   always_ff @(posedge clk) begin
      if (lk_valid) begin
         resp <= resp_d;
      end
   end

endmodule

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

   typedef enum logic [1:0] {
      CACHE_OP_LOOKUP = 2'd0,   // probe only
      CACHE_OP_ALLOC  = 2'd1,   // probe, fill victim on miss
      CACHE_OP_INVAL  = 2'd2    // drop the hit line
   } cache_op_e;

   typedef struct packed {
      logic [`CACHE_TAG_W-1:0]    tag;
      logic [`CACHE_NLINES_W-1:0] index;
      logic [`CACHE_OFFSET_W-1:0] offset;
   } cache_addr_fields_s;

   // same bits seen as one word or as tag/index/offset
   typedef union packed {
      logic [`CACHE_ADDR_W-1:0] word;
      cache_addr_fields_s       fields;
   } cache_addr_u;

   typedef struct packed {
      cache_op_e   op;
      cache_addr_u addr;
   } cache_req_s;

   typedef struct packed {
      logic                       hit;
      logic [`CACHE_NWAYS_W-1:0]  way;        // way used by the request
      logic [`CACHE_NWAYS_W-1:0]  victim;     // policy victim for this line
      logic                       evict;      // valid line pushed out by an alloc
      logic [`CACHE_TAG_W-1:0]    evict_tag;
      cache_op_e                  op;         // echoed from the request
      logic [`CACHE_NLINES_W-1:0] index;      // echoed from the request
   } cache_resp_s;

   // one-hot way vector to way number, zero vector gives way 0
   function automatic logic [`CACHE_NWAYS_W-1:0] cache_onehot_to_bin(
      input logic [`CACHE_N_WAYS-1:0] onehot);
      logic [`CACHE_NWAYS_W-1:0] bin;
      bin = '0;
      for (int i = 1; i < `CACHE_N_WAYS; i++) begin
         if (onehot[i]) bin = bin | `CACHE_NWAYS_W'(i);
      end
      return bin;
   endfunction

endpackage

`default_nettype wire

//--- cache_replacement_policy.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_replacement_policy import cache_pkg::*; #(
   parameter  int N_WAYS     = `CACHE_N_WAYS,
   parameter  int NLINES_W   = `CACHE_NLINES_W,
   parameter  int REP_POLICY = `CACHE_PLRU_TREE,
   localparam int NWAYS_W    = $clog2(N_WAYS)
) (
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire logic                write_en,     // one update per request
   input  wire logic [N_WAYS-1:0]   way_hit,      // accessed way, zero for none
   input  wire logic [NLINES_W-1:0] line_addr,
   output logic      [N_WAYS-1:0]   way_select,   // victim, one-hot
   output logic      [NWAYS_W-1:0]  way_select_bin
);

   if (REP_POLICY == `CACHE_LRU) begin : g_lru
      logic [N_WAYS*NWAYS_W-1:0] rank_q;
      logic [N_WAYS*NWAYS_W-1:0] rank_d;
      logic [NWAYS_W-1:0]        rank [N_WAYS];
      logic [NWAYS_W-1:0]        hit_rank;

      always_comb begin
         // an all-zero word means the line was never touched, use way order
         for (int w = 0; w < N_WAYS; w++) begin
            rank[w] = (|rank_q) ? rank_q[w*NWAYS_W +: NWAYS_W] : NWAYS_W'(w);
         end
         hit_rank = rank[cache_onehot_to_bin(way_hit)];
         for (int w = 0; w < N_WAYS; w++) begin
            if (way_hit[w]) begin
               rank_d[w*NWAYS_W +: NWAYS_W] = '1;   // most recent gets top rank
            end else if (rank[w] > hit_rank) begin
               rank_d[w*NWAYS_W +: NWAYS_W] = rank[w] - 1'b1;
            end else begin
               rank_d[w*NWAYS_W +: NWAYS_W] = rank[w];
            end
            way_select[w] = (rank[w] == '0);   // rank 0 is least recent
         end
         if (!(|way_hit)) begin
            rank_d = rank_q;   // nothing accessed, keep ranks
         end
      end

      cache_line_regfile #(.ADDR_W(NLINES_W), .DATA_W(N_WAYS*NWAYS_W)) u_state (
         .clk (clk), .rst (rst), .we (write_en), .addr (line_addr),
         .w_data (rank_d), .r_data (rank_q)
      );

      assign way_select_bin = cache_onehot_to_bin(way_select);

   end else if (REP_POLICY == `CACHE_PLRU_MRU) begin : g_plru_mru
      logic [N_WAYS-1:0] mru_q;
      logic [N_WAYS-1:0] mru_d;
      logic              lower_used;

      // once every way is marked, restart with just the latest access
      assign mru_d = (&(mru_q | way_hit)) ? way_hit : (mru_q | way_hit);

      always_comb begin
         lower_used = 1'b1;
         for (int w = 0; w < N_WAYS; w++) begin
            way_select[w] = lower_used && !mru_q[w];   // lowest unmarked way
            lower_used    = lower_used && mru_q[w];
         end
      end

      cache_line_regfile #(.ADDR_W(NLINES_W), .DATA_W(N_WAYS)) u_state (
         .clk (clk), .rst (rst), .we (write_en), .addr (line_addr),
         .w_data (mru_d), .r_data (mru_q)
      );

      assign way_select_bin = cache_onehot_to_bin(way_select);

   end else begin : g_plru_tree
      // node n has children 2n and 2n+1, leaf N_WAYS+w is way w
      logic [N_WAYS-1:1]  tree_q;
      logic [N_WAYS-1:1]  tree_d;
      logic [NWAYS_W:0]   sel_node;
      logic [NWAYS_W:0]   upd_node;
      logic [NWAYS_W-1:0] hit_bin;
      logic               dir;

      // victim walk, 0 goes left and 1 goes right
      always_comb begin
         sel_node = 1;
         for (int l = 0; l < NWAYS_W; l++) begin
            sel_node = {sel_node[NWAYS_W-1:0], tree_q[sel_node]};
         end
      end

      // every node on the accessed path points to the other side
      always_comb begin
         hit_bin  = cache_onehot_to_bin(way_hit);
         tree_d   = tree_q;
         upd_node = 1;
         dir      = 1'b0;
         if (|way_hit) begin
            for (int l = 0; l < NWAYS_W; l++) begin
               dir              = hit_bin[NWAYS_W-1-l];   // msb picks the root branch
               tree_d[upd_node] = !dir;
               upd_node         = {upd_node[NWAYS_W-1:0], dir};
            end
         end
      end

      cache_line_regfile #(.ADDR_W(NLINES_W), .DATA_W(N_WAYS-1)) u_state (
         .clk (clk), .rst (rst), .we (write_en), .addr (line_addr),
         .w_data (tree_d), .r_data (tree_q)
      );

      assign way_select_bin = sel_node[NWAYS_W-1:0];   // leaf id minus N_WAYS
      assign way_select     = N_WAYS'(1) << way_select_bin;
   end

endmodule

`default_nettype wire

//--- cache_req_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_req_decoder import cache_pkg::*; (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       req_valid,   // one-cycle request strobe
   input  wire cache_req_s req,
   output logic            dec_valid,   // stage-1 strobe
   output cache_req_s      dec_req      // registered, split request
);

   cache_req_s req_split;

   // flat address word carved into tag, index and offset
   always_comb begin
      req_split = '0;
      req_split.addr.fields.tag    = req.addr.word[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
      req_split.addr.fields.index  = req.addr.word[`CACHE_OFFSET_W +: `CACHE_NLINES_W];
      req_split.addr.fields.offset = req.addr.word[`CACHE_OFFSET_W-1:0];

      case (req.op)
         CACHE_OP_ALLOC: req_split.op = CACHE_OP_ALLOC;
         CACHE_OP_INVAL: req_split.op = CACHE_OP_INVAL;
         default:        req_split.op = CACHE_OP_LOOKUP;   // reserved code only probes
      endcase

      // idle cycles carry a quiet lookup of address 0
      if (!req_valid) begin
         req_split = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= req_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dec_req <= '0;
      end else begin
         dec_req <= req_split;
      end
   end

endmodule

`default_nettype wire

//--- cache_tag_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_tag_ctrl_top import cache_pkg::*; (
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       req_valid,
   input  wire cache_req_s req,
   output logic            resp_valid,   // 2 cycles after req_valid
   output cache_resp_s     resp
);

   logic                      dec_valid;
   cache_req_s                dec_req;
   logic                      lk_valid;
   cache_req_s                lk_req;
   logic                      hit;
   logic [`CACHE_NWAYS_W-1:0] hit_way;
   logic [`CACHE_NWAYS_W-1:0] victim_way;
   logic                      victim_valid;
   logic [`CACHE_TAG_W-1:0]   victim_tag;

   // stage 1 registers the request
   cache_req_decoder u_decoder (
      .clk (clk), .rst (rst),
      .req_valid (req_valid), .req (req),
      .dec_valid (dec_valid), .dec_req (dec_req)
   );

   // stage 2 probes and updates the tag store
   cache_tag_lookup u_lookup (
      .clk (clk), .rst (rst),
      .dec_valid (dec_valid), .dec_req (dec_req),
      .lk_valid (lk_valid), .lk_req (lk_req),
      .hit (hit), .hit_way (hit_way), .victim_way (victim_way),
      .victim_valid (victim_valid), .victim_tag (victim_tag)
   );

   cache_lookup_resp u_resp (
      .clk (clk), .rst (rst),
      .lk_valid (lk_valid), .lk_req (lk_req),
      .hit (hit), .hit_way (hit_way), .victim_way (victim_way),
      .victim_valid (victim_valid), .victim_tag (victim_tag),
      .resp_valid (resp_valid), .resp (resp)
   );

endmodule

`default_nettype wire

//--- cache_tag_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_tag_lookup import cache_pkg::*; (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       dec_valid,
   input  wire cache_req_s                 dec_req,
   output logic                            lk_valid,
   output cache_req_s                      lk_req,
   output logic                            hit,
   output logic [`CACHE_NWAYS_W-1:0]       hit_way,
   output logic [`CACHE_NWAYS_W-1:0]       victim_way,
   output logic                            victim_valid,   // victim held a line
   output logic [`CACHE_TAG_W-1:0]         victim_tag      // tag of that line
);

   localparam int N_WAYS = `CACHE_N_WAYS;

   logic [`CACHE_NLINES_W-1:0] line_idx;
   logic [`CACHE_TAG_W-1:0]    req_tag;
   logic [N_WAYS-1:0]          valid_q;
   logic [N_WAYS-1:0]          valid_d;
   logic                       valid_we;
   logic [`CACHE_TAG_W-1:0]    tag_q [N_WAYS];
   logic [N_WAYS-1:0]          tag_we;
   logic [N_WAYS-1:0]          hit_vec;
   logic [N_WAYS-1:0]          way_hit;         // access vector fed to the policy
   logic [N_WAYS-1:0]          way_select;      // policy victim, one-hot
   logic [`CACHE_NWAYS_W-1:0]  way_select_bin;
   logic                       alloc_miss;
   logic                       inval_hit;

   assign line_idx = dec_req.addr.fields.index;
   assign req_tag  = dec_req.addr.fields.tag;

   // valid bits, one per way, all ways of a line in one word
   cache_line_regfile #(.ADDR_W(`CACHE_NLINES_W), .DATA_W(N_WAYS)) u_valid (
      .clk    (clk),
      .rst    (rst),
      .we     (valid_we),
      .addr   (line_idx),
      .w_data (valid_d),
      .r_data (valid_q)
   );

   for (genvar w = 0; w < N_WAYS; w++) begin : g_tag_way
      cache_line_regfile #(.ADDR_W(`CACHE_NLINES_W), .DATA_W(`CACHE_TAG_W)) u_tag (
         .clk    (clk),
         .rst    (rst),
         .we     (tag_we[w]),
         .addr   (line_idx),
         .w_data (req_tag),
         .r_data (tag_q[w])
      );
   end

   // compare in every way at once
   always_comb begin
      for (int w = 0; w < N_WAYS; w++) begin
         hit_vec[w] = valid_q[w] && (tag_q[w] == req_tag);
      end
   end

   assign hit        = |hit_vec;
   assign alloc_miss = dec_valid && (dec_req.op == CACHE_OP_ALLOC) && !hit;
   assign inval_hit  = dec_valid && (dec_req.op == CACHE_OP_INVAL) && hit;

   always_comb begin
      way_hit = '0;   // misses and invals leave the policy alone
      if (hit && dec_req.op != CACHE_OP_INVAL) begin
         way_hit = hit_vec;
      end else if (alloc_miss) begin
         way_hit = way_select;   // filled way becomes most recent
      end
   end

   // fill sets the victim's bit, inval drops the hit way
   assign valid_we = alloc_miss || inval_hit;
   assign valid_d  = alloc_miss ? (valid_q | way_select) : (valid_q & ~hit_vec);
   assign tag_we   = alloc_miss ? way_select : '0;

   // state only depends on the stored word, so no loop through way_hit
   cache_replacement_policy #(
      .N_WAYS     (N_WAYS),
      .NLINES_W   (`CACHE_NLINES_W),
      .REP_POLICY (`CACHE_REP_POLICY)
   ) u_policy (
      .clk            (clk),
      .rst            (rst),
      .write_en       (dec_valid),
      .way_hit        (way_hit),
      .line_addr      (line_idx),
      .way_select     (way_select),
      .way_select_bin (way_select_bin)
   );

   assign lk_valid     = dec_valid;
   assign lk_req       = dec_req;
   assign hit_way      = cache_onehot_to_bin(hit_vec);
   assign victim_way   = way_select_bin;
   assign victim_valid = valid_q[way_select_bin];   // read before the fill
   assign victim_tag   = tag_q[way_select_bin];

endmodule

`default_nettype wire

//--- list.f
+incdir+.
cache_pkg.sv
cache_line_regfile.sv
cache_replacement_policy.sv
cache_tag_lookup.sv
cache_req_decoder.sv
cache_lookup_resp.sv
cache_tag_ctrl_top.sv
tb_cache_tag_ctrl.sv

//--- tb_cache_tag_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module tb_cache_tag_ctrl import cache_pkg::*; ();

   localparam int N_WAYS      = `CACHE_N_WAYS;
   localparam int NWAYS_W     = `CACHE_NWAYS_W;
   localparam int NLINES_W    = `CACHE_NLINES_W;
   localparam int OFF_W       = `CACHE_OFFSET_W;
   localparam int TAG_W       = `CACHE_TAG_W;
   localparam int DRAIN_LIMIT = 50;   // cycles to wait for outstanding responses

   logic        clk;
   logic        rst;
   logic        req_valid;
   cache_req_s  req;
   logic        resp_valid;
   cache_resp_s resp;

   // reference model, one entry per line
   logic [N_WAYS-1:0] valid_m [2**NLINES_W];
   logic [TAG_W-1:0]  tags_m  [2**NLINES_W][N_WAYS];
   logic [N_WAYS-1:1] tree_m  [2**NLINES_W];   // node n has children 2n and 2n+1

   cache_resp_s exp_q [$];   // expected responses in request order
   int          due_q [$];   // negedge number each one must show up at
   cache_resp_s last_exp;
   cache_resp_s mon_exp;
   int          mon_due;
   int          neg_count = 0;
   int          check_errors = 0;
   int          protocol_errors = 0;
   int          timeout_errors = 0;
   int unsigned lcg_state = 97058;
   int          fill_order [N_WAYS] = '{0, 4, 2, 6, 1, 5, 3, 7};
   logic [TAG_W-1:0] t;

   cache_tag_ctrl_top uut (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req        (req),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state >> 8;   // low bits of an lcg cycle too fast
   endfunction

   // walk from the root, 0 goes left and 1 goes right
   function automatic logic [NWAYS_W-1:0] tree_victim(input logic [NLINES_W-1:0] idx);
      int node;
      node = 1;
      for (int l = 0; l < NWAYS_W; l++) begin
         node = 2 * node + tree_m[idx][node];
      end
      return NWAYS_W'(node - N_WAYS);
   endfunction

   task automatic tree_touch(input logic [NLINES_W-1:0] idx, input int way);
      int   node;
      logic dir;
      node = 1;
      for (int l = NWAYS_W - 1; l >= 0; l--) begin
         dir               = way[l];
         tree_m[idx][node] = !dir;   // point away from the latest access
         node              = 2 * node + dir;
      end
   endtask

   // predicts one response and moves the model on
   task automatic model_request(input cache_op_e op, input logic [TAG_W-1:0] tag,
                                input logic [NLINES_W-1:0] idx, output cache_resp_s exp);
      int                 hw;
      logic [NWAYS_W-1:0] vic;
      hw = -1;
      for (int w = 0; w < N_WAYS; w++) begin
         if (valid_m[idx][w] && tags_m[idx][w] == tag) hw = w;
      end
      vic        = tree_victim(idx);
      exp        = '0;
      exp.hit    = (hw >= 0);
      exp.victim = vic;
      exp.op     = op;
      exp.index  = idx;
      if (hw >= 0) exp.way = NWAYS_W'(hw);
      if (op == CACHE_OP_ALLOC && hw < 0) begin
         exp.way = vic;   // fill goes to the victim
         if (valid_m[idx][vic]) begin
            exp.evict     = 1'b1;
            exp.evict_tag = tags_m[idx][vic];
         end
         valid_m[idx][vic] = 1'b1;
         tags_m[idx][vic]  = tag;
         tree_touch(idx, vic);
      end else if (op == CACHE_OP_INVAL) begin
         if (hw >= 0) valid_m[idx][hw] = 1'b0;   // tree left as it is
      end else if (hw >= 0) begin
         tree_touch(idx, hw);   // lookup or alloc hit
      end
   endtask

   task automatic send(input cache_op_e op, input logic [TAG_W-1:0] tag,
                       input logic [NLINES_W-1:0] idx);
      cache_resp_s exp;
      cache_req_s  r;
      @(posedge clk);
      model_request(op, tag, idx, exp);
      exp_q.push_back(exp);
      due_q.push_back(neg_count + 3);   // seen at the next negedge, answered 2 cycles on
      r           = '0;
      r.op        = op;
      r.addr.word = {tag, idx, OFF_W'(lcg_next())};   // offset is don't care
      req_valid  <= 1'b1;
      req        <= r;
      last_exp    = exp;
   endtask

   task automatic go_idle();
      @(posedge clk);
      req_valid <= 1'b0;
      req       <= '0;
   endtask

   task automatic end_run();
      $display("errors: %0d check, %0d protocol, %0d timeout",
               check_errors, protocol_errors, timeout_errors);
      if (check_errors + protocol_errors + timeout_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         timeout_errors++;
         $display("timeout: %0d responses still missing after %0d cycles",
                  exp_q.size(), DRAIN_LIMIT);
         exp_q.delete();   // stale entries would shift every later check
         due_q.delete();
      end
   endtask

   // outputs are sampled on the falling edge, away from the DUT's updates
   always @(negedge clk) begin
      neg_count = neg_count + 1;
      if (resp_valid === 1'b1 && exp_q.size() == 0) begin
         protocol_errors++;
         $display("unexpected response at %0t with no request outstanding", $time);
      end else if (resp_valid === 1'b1) begin
         mon_exp = exp_q.pop_front();
         mon_due = due_q.pop_front();
         assert (neg_count == mon_due) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: response %0d cycles off its slot",
                     $time, neg_count - mon_due);
         end
         assert (resp === mon_exp) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: op %0d line %0d ", $time, mon_exp.op,
                     mon_exp.index, "got hit %b way %0d victim %0d evict %b tag %h, ",
                     resp.hit, resp.way, resp.victim, resp.evict, resp.evict_tag,
                     "expected hit %b way %0d victim %0d evict %b tag %h",
                     mon_exp.hit, mon_exp.way, mon_exp.victim, mon_exp.evict,
                     mon_exp.evict_tag);
         end
      end else begin
         assert (resp_valid === 1'b0) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: resp_valid is %b", $time, resp_valid);
         end
         if (due_q.size() != 0 && due_q[0] <= neg_count) begin
            protocol_errors++;   // slot passed without a strobe
            $display("response missing at %0t for line %0d", $time, exp_q[0].index);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
         end
      end
   end

   initial begin
      rst       = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      for (int i = 0; i < 2**NLINES_W; i++) begin
         valid_m[i] = '0;
         tree_m[i]  = '0;
         for (int w = 0; w < N_WAYS; w++) tags_m[i][w] = '0;
      end
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      repeat (4) @(posedge clk);   // monitor flags any strobe while idle

      // cold lookups, each line probed twice, all miss on way 0
      for (int i = 0; i < 2**NLINES_W; i++) begin
         t = TAG_W'(16'h0100 + lcg_next() % 4);
         send(CACHE_OP_LOOKUP, t, NLINES_W'(i));
         send(CACHE_OP_LOOKUP, t, NLINES_W'(i));
      end
      go_idle();
      wait_drain();

      // fill one line, tree order
      for (int i = 0; i < N_WAYS; i++) begin
         send(CACHE_OP_ALLOC, TAG_W'(16'h1000 + i), 4'd5);
         assert (last_exp.way == NWAYS_W'(fill_order[i])) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: model filled way %0d, fill %0d wants way %0d",
                     $time, last_exp.way, i, fill_order[i]);
         end
      end
      for (int i = 0; i < N_WAYS; i++) begin
         send(CACHE_OP_LOOKUP, TAG_W'(16'h1000 + i), 4'd5);   // all hit
      end
      go_idle();
      wait_drain();

      // evictions on a full line, with hits moving the victim
      for (int i = 0; i < 6; i++) begin
         send(CACHE_OP_LOOKUP, tags_m[5][lcg_next() % N_WAYS], 4'd5);
         send(CACHE_OP_ALLOC, TAG_W'(16'h2000 + i), 4'd5);
      end
      go_idle();
      wait_drain();

      // inval of present and absent tags
      t = tags_m[5][3];
      send(CACHE_OP_INVAL, t, 4'd5);
      send(CACHE_OP_LOOKUP, t, 4'd5);
      send(CACHE_OP_INVAL, TAG_W'(16'hdead), 4'd5);
      send(CACHE_OP_LOOKUP, tags_m[5][2], 4'd5);
      send(CACHE_OP_ALLOC, TAG_W'(16'h3000), 4'd5);   // goes to the tree victim, not way 3
      go_idle();
      wait_drain();

      // alloc then an immediate request to the same line
      send(CACHE_OP_ALLOC, TAG_W'(16'h3100), 4'd12);
      send(CACHE_OP_LOOKUP, TAG_W'(16'h3100), 4'd12);
      send(CACHE_OP_ALLOC, TAG_W'(16'h3101), 4'd12);
      send(CACHE_OP_ALLOC, TAG_W'(16'h3101), 4'd12);

      // random back-to-back traffic on a few lines and tags
      for (int n = 0; n < 400; n++) begin
         int unsigned r;
         cache_op_e   op;
         r  = lcg_next() % 8;
         op = (r < 3) ? CACHE_OP_LOOKUP : (r < 6) ? CACHE_OP_ALLOC : CACHE_OP_INVAL;
         send(op, TAG_W'(16'h4000 + lcg_next() % 12), NLINES_W'(8 + lcg_next() % 4));
         if (lcg_next() % 16 == 0) go_idle();   // occasional gap
      end
      go_idle();
      wait_drain();
      repeat (5) @(posedge clk);
      end_run();
   end

endmodule

`default_nettype wire
